// ==== ov7670_color_track.f ====
src/ov7670_pkg.sv
src/ov7670_capture.sv
src/frame_buffer.sv
src/color_proc.sv
src/vga_sync.sv
src/vga_display.sv
src/top_ov7670.sv
verif/top_ov7670_props.sv
verif/tb_top_ov7670.sv

// ==== src/color_proc.sv ====
`timescale 1ns/1ps

module color_proc #(
  parameter int img_cols = 80,
  parameter int img_rows = 60,
  parameter int addr_w   = 13
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          proc_ctrl,
  output logic [addr_w-1:0]             orig_addr,
  input  logic [ov7670_pkg::pxl_w-1:0]  orig_pxl,
  output logic                          proc_we,
  output logic [addr_w-1:0]             proc_addr,
  output logic [ov7670_pkg::pxl_w-1:0]  proc_pxl,
  output ov7670_pkg::filter_t           filter_sel,
  output logic [7:0]                    centroid,
  output logic [2:0]                    proximity
);

  import ov7670_pkg::*;

  localparam int                col_w     = $clog2(img_cols);
  localparam logic [addr_w-1:0] last_addr = addr_w'(img_cols * img_rows - 1);
  localparam logic [col_w-1:0]  last_col  = col_w'(img_cols - 1);

  logic [2:0]        ctrl_q;     // sync flops plus edge reg
  logic              ctrl_rise;
  filter_t           sweep_filt; // filter in use for the running sweep
  logic [col_w-1:0]  rd_col;
  logic              s1_valid;
  logic              s1_first;
  logic              s1_last;
  logic [addr_w-1:0] s1_addr;
  logic [col_w-1:0]  s1_col;
  logic              s2_last;
  logic [3:0]        nib_r;
  logic [3:0]        nib_g;
  logic [3:0]        nib_b;
  logic              match;
  logic [col_w-1:0]  min_col;
  logic [col_w-1:0]  max_col;
  logic [addr_w-1:0] match_cnt;
  logic [col_w:0]    col_sum;

  // half the msb position of the count, capped at 7
  function automatic logic [2:0] prox_of(input logic [addr_w-1:0] cnt);
    int msb;
    msb = 0;
    for (int i = 0; i < addr_w; i++) begin
      if (cnt[i]) msb = i;
    end
    return (msb / 2 > 7) ? 3'd7 : 3'(msb / 2);
  endfunction

  assign ctrl_rise = ctrl_q[1] & ~ctrl_q[2];
  assign nib_r     = orig_pxl[pxl_w-1 -: 4];
  assign nib_g     = orig_pxl[pxl_w-5 -: 4];
  assign nib_b     = orig_pxl[3:0];
  assign col_sum   = {1'b0, min_col} + {1'b0, max_col};

  // dominant color test on the returned pixel
  always_comb begin
    case (sweep_filt)
      filt_red:   match = nib_r >= color_thresh && nib_r > nib_g && nib_r > nib_b;
      filt_green: match = nib_g >= color_thresh && nib_g > nib_r && nib_g > nib_b;
      filt_blue:  match = nib_b >= color_thresh && nib_b > nib_r && nib_b > nib_g;
      default:    match = 1'b0;
    endcase
  end

  // filter select and read sweep
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_q     <= '0;
      filter_sel <= filt_none;
      sweep_filt <= filt_none;
      orig_addr  <= '0;
      rd_col     <= '0;
      s1_valid   <= 1'b0;
      s1_first   <= 1'b0;
      s1_last    <= 1'b0;
      s2_last    <= 1'b0;
    end else begin
      ctrl_q <= {ctrl_q[1:0], proc_ctrl};
      if (ctrl_rise) begin
        case (filter_sel)
          filt_none:  filter_sel <= filt_red;
          filt_red:   filter_sel <= filt_green;
          filt_green: filter_sel <= filt_blue;
          default:    filter_sel <= filt_none;
        endcase
      end
      if (orig_addr == '0) sweep_filt <= filter_sel; // new sweep picks up the filter
      orig_addr <= (orig_addr == last_addr) ? '0 : orig_addr + 1'b1;
      rd_col    <= (rd_col == last_col || orig_addr == last_addr) ? '0 : rd_col + 1'b1;
      s1_valid  <= 1'b1;
      s1_first  <= orig_addr == '0;
      s1_last   <= orig_addr == last_addr;
      s2_last   <= s1_valid & s1_last;
    end
  end

  always_ff @(posedge clk) begin
    s1_addr   <= orig_addr;
    s1_col    <= rd_col;
    proc_addr <= s1_addr;
    proc_pxl  <= (sweep_filt == filt_none || match) ? orig_pxl : '0;
  end

  // write strobe, match statistics and results
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      proc_we   <= 1'b0;
      min_col   <= '0;
      max_col   <= '0;
      match_cnt <= '0;
      centroid  <= '0;
      proximity <= '0;
    end else begin
      proc_we <= s1_valid;
      if (s1_valid) begin
        if (s1_first) begin  // restart stats with the first pixel
          min_col   <= match ? s1_col : last_col;
          max_col   <= match ? s1_col : '0;
          match_cnt <= addr_w'(match);
        end else if (match) begin
          if (s1_col < min_col) min_col <= s1_col;
          if (s1_col > max_col) max_col <= s1_col;
          match_cnt <= match_cnt + 1'b1;
        end
      end
      if (s2_last) begin     // sweep done, stats still hold it
        centroid  <= (match_cnt == '0) ? 8'd0 : 8'(col_sum >> 1);
        proximity <= prox_of(match_cnt);
      end
    end
  end

endmodule

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
  parameter int addr_w = 13,
  parameter int depth  = 4800
) (
  input  logic                          clk,
  input  logic                          wea,
  input  logic [addr_w-1:0]             addra,
  input  logic [ov7670_pkg::pxl_w-1:0]  dina,
  input  logic [addr_w-1:0]             addrb,
  output logic [ov7670_pkg::pxl_w-1:0]  doutb
);

  import ov7670_pkg::*;

  logic [pxl_w-1:0] mem [depth]; // one pixel per word

  // write port
  always_ff @(posedge clk) begin
    if (wea) mem[addra] <= dina;
  end

  // read port, one cycle latency
  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
  end

endmodule

// ==== src/ov7670_capture.sv ====
`timescale 1ns/1ps

module ov7670_capture #(
  parameter int img_cols = 80,
  parameter int img_rows = 60,
  parameter int addr_w   = 13
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          pclk,
  input  logic                          vsync,
  input  logic                          href,
  input  logic [7:0]                    data,
  output logic                          cap_we,
  output logic [addr_w-1:0]             cap_addr,
  output logic [ov7670_pkg::pxl_w-1:0]  cap_pxl
);

  localparam logic [addr_w-1:0] last_addr = addr_w'(img_cols * img_rows - 1);

  logic [2:0]        pclk_q;   // two sync flops plus edge reg
  logic [2:0]        vsync_q;
  logic [1:0]        href_q;
  logic [7:0]        data_q1;  // data delayed like the strobes
  logic [7:0]        data_q2;
  logic              pclk_rise;
  logic              vs_rise;
  logic              byte_sel; // 0: first byte (red), 1: second byte (green, blue)
  logic              full;     // frame already holds all pixels
  logic [addr_w-1:0] wr_cnt;
  logic [3:0]        red_nib;

  assign pclk_rise = pclk_q[1] & ~pclk_q[2];
  assign vs_rise   = vsync_q[1] & ~vsync_q[2];

  // synchronizers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pclk_q  <= '0;
      vsync_q <= '0;
      href_q  <= '0;
    end else begin
      pclk_q  <= {pclk_q[1:0], pclk};
      vsync_q <= {vsync_q[1:0], vsync};
      href_q  <= {href_q[0], href};
    end
  end

  always_ff @(posedge clk) begin
    data_q1 <= data;
    data_q2 <= data_q1; // lines up with pclk_q[1]
  end

  // byte phase and address count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_we   <= 1'b0;
      byte_sel <= 1'b0;
      full     <= 1'b0;
      wr_cnt   <= '0;
    end else begin
      cap_we <= 1'b0;
      if (vs_rise) begin   // new frame
        wr_cnt   <= '0;
        full     <= 1'b0;
        byte_sel <= 1'b0;
      end else if (!href_q[1]) begin
        byte_sel <= 1'b0;  // realign at each line
      end else if (pclk_rise) begin
        byte_sel <= ~byte_sel;
        if (byte_sel) begin
          cap_we <= ~full; // drop pixels past the last address
          if (wr_cnt == last_addr) full <= 1'b1;
          else wr_cnt <= wr_cnt + 1'b1;
        end
      end
    end
  end

  // pixel assembly
  always_ff @(posedge clk) begin
    if (pclk_rise && href_q[1]) begin
      if (!byte_sel) begin
        red_nib <= data_q2[3:0];           // low nibble only in rgb444
      end else begin
        cap_pxl  <= {red_nib, data_q2};    // green high, blue low
        cap_addr <= wr_cnt;
      end
    end
  end

endmodule

// ==== src/ov7670_pkg.sv ====
package ov7670_pkg;

  // stored pixel: rgb444, red in the top nibble
  localparam int pxl_w = 12;

  // vga counter widths
  localparam int vga_cols_w = 10;
  localparam int vga_rows_w = 10;

  // horizontal timing, in pixels
  localparam int h_visible = 640;
  localparam int h_front   = 16;
  localparam int h_sync    = 96;
  localparam int h_back    = 48;

  // vertical timing, in lines
  localparam int v_visible = 480;
  localparam int v_front   = 10;
  localparam int v_sync    = 2;
  localparam int v_back    = 33;

  // lowest nibble value for a dominant color to count
  localparam int color_thresh = 8;

  // one-hot filter select, bit order follows the pixel nibbles
  typedef enum logic [2:0] {
    filt_none  = 3'b000,
    filt_red   = 3'b100,
    filt_green = 3'b010,
    filt_blue  = 3'b001
  } filter_t;

endpackage

// ==== src/top_ov7670.sv ====
`timescale 1ns/1ps

module top_ov7670 #(
  parameter int img_cols = 80,
  parameter int img_rows = 60,
  parameter int addr_w   = 13   // 80*60 fits in 2^13
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ov7670_pclk,
  input  logic                 ov7670_vsync,
  input  logic                 ov7670_href,
  input  logic [7:0]           ov7670_d,
  input  logic                 proc_ctrl,   // steps the color filter
  output logic [3:0]           vga_red,
  output logic [3:0]           vga_green,
  output logic [3:0]           vga_blue,
  output logic                 vga_hsync,
  output logic                 vga_vsync,
  output logic [7:0]           centroid,
  output logic [2:0]           proximity,   // how close the object is
  output ov7670_pkg::filter_t  filter_sel
);

  import ov7670_pkg::*;

  logic                  cap_we;
  logic [addr_w-1:0]     cap_addr;
  logic [pxl_w-1:0]      cap_pxl;
  logic [addr_w-1:0]     orig_addr;
  logic [pxl_w-1:0]      orig_pxl;
  logic                  proc_we;
  logic [addr_w-1:0]     proc_addr;
  logic [pxl_w-1:0]      proc_pxl;
  logic [addr_w-1:0]     disp_addr;
  logic [pxl_w-1:0]      disp_pxl;
  logic                  visible;
  logic                  new_pxl;
  logic                  hsync;
  logic                  vsync;
  logic [vga_cols_w-1:0] col;
  logic [vga_rows_w-1:0] row;

  ov7670_capture #(.img_cols(img_cols), .img_rows(img_rows), .addr_w(addr_w)) capture (
    .clk(clk), .rst_n(rst_n), .pclk(ov7670_pclk), .vsync(ov7670_vsync),
    .href(ov7670_href), .data(ov7670_d),
    .cap_we(cap_we), .cap_addr(cap_addr), .cap_pxl(cap_pxl)
  );

  // camera image, before processing
  frame_buffer #(.addr_w(addr_w), .depth(img_cols * img_rows)) cam_fb (
    .clk(clk), .wea(cap_we), .addra(cap_addr), .dina(cap_pxl),
    .addrb(orig_addr), .doutb(orig_pxl)
  );

  color_proc #(.img_cols(img_cols), .img_rows(img_rows), .addr_w(addr_w)) img_proc (
    .clk(clk), .rst_n(rst_n), .proc_ctrl(proc_ctrl),
    .orig_addr(orig_addr), .orig_pxl(orig_pxl),
    .proc_we(proc_we), .proc_addr(proc_addr), .proc_pxl(proc_pxl),
    .filter_sel(filter_sel), .centroid(centroid), .proximity(proximity)
  );

  // filtered image for the display
  frame_buffer #(.addr_w(addr_w), .depth(img_cols * img_rows)) proc_fb (
    .clk(clk), .wea(proc_we), .addra(proc_addr), .dina(proc_pxl),
    .addrb(disp_addr), .doutb(disp_pxl)
  );

  vga_sync i_vga (
    .clk(clk), .rst_n(rst_n), .visible(visible), .new_pxl(new_pxl),
    .hsync(hsync), .vsync(vsync), .col(col), .row(row)
  );

  vga_display #(.img_cols(img_cols), .img_rows(img_rows), .addr_w(addr_w)) i_display (
    .clk(clk), .rst_n(rst_n), .visible(visible), .new_pxl(new_pxl),
    .hsync(hsync), .vsync(vsync), .col(col), .row(row),
    .centroid(centroid), .proximity(proximity),
    .disp_addr(disp_addr), .disp_pxl(disp_pxl),
    .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

endmodule

// ==== src/vga_display.sv ====
`timescale 1ns/1ps

module vga_display #(
  parameter int img_cols = 80,
  parameter int img_rows = 60,
  parameter int addr_w   = 13
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               visible,
  input  logic                               new_pxl,
  input  logic                               hsync,
  input  logic                               vsync,
  input  logic [ov7670_pkg::vga_cols_w-1:0]  col,
  input  logic [ov7670_pkg::vga_rows_w-1:0]  row,
  input  logic [7:0]                         centroid,
  input  logic [2:0]                         proximity,
  output logic [addr_w-1:0]                  disp_addr,
  input  logic [ov7670_pkg::pxl_w-1:0]       disp_pxl,
  output logic [3:0]                         vga_red,
  output logic [3:0]                         vga_green,
  output logic [3:0]                         vga_blue,
  output logic                               vga_hsync,
  output logic                               vga_vsync
);

  import ov7670_pkg::*;

  logic in_win;   // image window in the top-left corner
  logic on_mark;
  logic win_d;    // first stage, taken on the pixel strobe
  logic mark_d;
  logic hs_d;
  logic vs_d;
  logic pxl_d;    // strobe delayed to the output stage

  assign in_win    = visible && (col < img_cols) && (row < img_rows);
  assign on_mark   = (col == vga_cols_w'(centroid)) && (proximity != 3'd0);
  assign disp_addr = in_win ? addr_w'(row * img_cols + col) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_d     <= 1'b0;
      mark_d    <= 1'b0;
      hs_d      <= 1'b1;
      vs_d      <= 1'b1;
      pxl_d     <= 1'b0;
      vga_hsync <= 1'b1;   // syncs idle high
      vga_vsync <= 1'b1;
      vga_red   <= '0;
      vga_green <= '0;
      vga_blue  <= '0;
    end else begin
      pxl_d <= new_pxl;
      if (new_pxl) begin
        win_d  <= in_win;
        mark_d <= on_mark;
        hs_d   <= hsync;
        vs_d   <= vsync;
      end
      if (pxl_d) begin     // outputs move once per pixel, held for both clocks
        vga_hsync <= hs_d;   // same delay as the colors
        vga_vsync <= vs_d;
        if (!win_d) begin
          {vga_red, vga_green, vga_blue} <= '0;   // black outside and in blanking
        end else if (mark_d) begin
          {vga_red, vga_green, vga_blue} <= '1;   // white centroid column
        end else begin
          {vga_red, vga_green, vga_blue} <= disp_pxl[pxl_w-1:0];
        end
      end
    end
  end

endmodule

// ==== src/vga_sync.sv ====
`timescale 1ns/1ps

module vga_sync (
  input  logic                               clk,
  input  logic                               rst_n,
  output logic                               visible,
  output logic                               new_pxl,
  output logic                               hsync,
  output logic                               vsync,
  output logic [ov7670_pkg::vga_cols_w-1:0]  col,
  output logic [ov7670_pkg::vga_rows_w-1:0]  row
);

  import ov7670_pkg::*;

  localparam int h_total = h_visible + h_front + h_sync + h_back; // 800
  localparam int v_total = v_visible + v_front + v_sync + v_back; // 525
  localparam int hs_beg  = h_visible + h_front;
  localparam int vs_beg  = v_visible + v_front;

  logic                  pxl_tgl;  // half rate pixel strobe
  logic [vga_cols_w-1:0] h_cnt;
  logic [vga_rows_w-1:0] v_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pxl_tgl <= 1'b0;
      h_cnt   <= '0;
      v_cnt   <= '0;
    end else begin
      pxl_tgl <= ~pxl_tgl;
      if (pxl_tgl) begin
        if (h_cnt == vga_cols_w'(h_total - 1)) begin
          h_cnt <= '0;
          // end of line, step the row
          v_cnt <= (v_cnt == vga_rows_w'(v_total - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  assign new_pxl = pxl_tgl;
  assign col     = h_cnt;
  assign row     = v_cnt;
  assign visible = (h_cnt < h_visible) && (v_cnt < v_visible);
  assign hsync   = !((h_cnt >= hs_beg) && (h_cnt < hs_beg + h_sync)); // active low
  assign vsync   = !((v_cnt >= vs_beg) && (v_cnt < vs_beg + v_sync));

endmodule

// ==== verif/tb_top_ov7670.sv ====
`timescale 1ns/1ps

module tb_top_ov7670;

  import ov7670_pkg::*;

  localparam int img_cols  = 80;
  localparam int img_rows  = 60;
  localparam int img_pix   = img_cols * img_rows;
  localparam int line_cyc  = 1600;                  // 800 pixels, one every second clock
  localparam int frame_cyc = 525 * line_cyc;
  localparam int cam_cyc   = img_pix * 8 + img_rows * 8 + 32; // 2 bytes of 4 clocks each
  localparam int sweep_wait = 2 * img_pix + 16;     // sweep in flight plus one clean sweep
  // two frame-start waits, one checked frame, 95 checked lines, two camera frames
  localparam int timeout_cyc = 3 * frame_cyc + 100 * line_cyc + 2 * (cam_cyc + sweep_wait);

  logic        clk;
  logic        rst_n;
  logic        ov7670_pclk;
  logic        ov7670_vsync;
  logic        ov7670_href;
  logic [7:0]  ov7670_d;
  logic        proc_ctrl;
  logic [3:0]  vga_red;
  logic [3:0]  vga_green;
  logic [3:0]  vga_blue;
  logic        vga_hsync;
  logic        vga_vsync;
  logic [7:0]  centroid;
  logic [2:0]  proximity;
  filter_t     filter_sel;

  logic [11:0] ref_img [img_pix];   // pixels sent by the camera model
  logic [11:0] exp_img [img_pix];   // expected processed image
  logic [31:0] rng = 32'd88;
  int          errors = 0;
  int          checks = 0;
  int          cycles;
  filter_t     step_order [5] = '{filt_red, filt_green, filt_blue, filt_none, filt_red};

  top_ov7670 #(.img_cols(img_cols), .img_rows(img_rows), .addr_w(13)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int fail_total();
    return errors + dut0.props0.fail_cnt;   // immediate plus concurrent failures
  endfunction

  function automatic logic [11:0] expected_color(input int col, input int row, input int mark);
    if (col >= img_cols || row >= img_rows) return 12'h000;  // outside window, blanking
    if (col == mark) return 12'hfff;                          // centroid marker
    return exp_img[row * img_cols + col];
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #5;   // inputs change just after the edge
  endtask

  task automatic send_byte(input logic [7:0] b);
    ov7670_d    = b;
    ov7670_pclk = 1'b0;
    wait_clk(2);
    ov7670_pclk = 1'b1;   // byte taken on this rising edge
    wait_clk(2);
  endtask

  task automatic send_frame();
    wait_clk(1);
    ov7670_vsync = 1'b1;  // rising vsync restarts the write address
    wait_clk(8);
    ov7670_vsync = 1'b0;
    wait_clk(8);
    for (int r = 0; r < img_rows; r++) begin
      ov7670_href = 1'b1;
      for (int c = 0; c < img_cols; c++) begin
        send_byte({4'h0, ref_img[r * img_cols + c][11:8]}); // red, low nibble
        send_byte(ref_img[r * img_cols + c][7:0]);          // green and blue
      end
      ov7670_pclk = 1'b0;
      ov7670_href = 1'b0;
      wait_clk(8);        // line gap
    end
  endtask

  task automatic pulse_ctrl();
    wait_clk(1);
    proc_ctrl = 1'b1;
    wait_clk(4);
    proc_ctrl = 1'b0;
    wait_clk(8);          // covers the two-flop sync and the edge register
  endtask

  task automatic make_random_frame();
    for (int i = 0; i < img_pix; i++) begin
      rng = lcg_step(rng);
      ref_img[i] = rng[27:16];
      exp_img[i] = rng[27:16];   // no filter, copied as is
    end
  endtask

  task automatic make_red_frame();
    logic in_block;
    for (int i = 0; i < img_pix; i++) begin
      rng = lcg_step(rng);
      in_block = (i % img_cols) inside {[20:29]} && (i / img_cols) inside {[10:19]};
      ref_img[i] = in_block ? 12'hf00 : {3{rng[19:16]}}; // gray has no dominant nibble
      exp_img[i] = in_block ? 12'hf00 : 12'h000;
    end
  endtask

  // frame starts at the vsync fall, row 490 col 0, then one pixel per two clocks
  task automatic check_display(input int num_pix, input int mark);
    int col;
    int row;
    do @(negedge clk); while (vga_vsync !== 1'b1);
    do @(negedge clk); while (vga_vsync !== 1'b0);
    col = 0;
    row = 490;
    repeat (num_pix) begin
      repeat (2) begin    // both clocks of the pixel
        compare("vga_rgb", {vga_red, vga_green, vga_blue}, expected_color(col, row, mark));
        compare("vga_hsync", vga_hsync, !(col >= 656 && col < 752));
        compare("vga_vsync", vga_vsync, !(row >= 490 && row < 492));
        @(negedge clk);
      end
      if (col == 799) begin
        col = 0;
        row = (row == 524) ? 0 : row + 1;
      end else begin
        col++;
      end
    end
  endtask

  initial begin
    int base;
    rst_n        = 1'b0;
    ov7670_pclk  = 1'b0;
    ov7670_vsync = 1'b0;
    ov7670_href  = 1'b0;
    ov7670_d     = 8'h00;
    proc_ctrl    = 1'b0;
    wait_clk(16);
    rst_n = 1'b1;
    wait_clk(4);
    $display("reset_state: %0d failures", fail_total());

    base = fail_total();
    make_random_frame();
    send_frame();
    wait_clk(sweep_wait);
    compare("centroid", centroid, 0);
    compare("proximity", proximity, 0);
    check_display(800 * 525, -1);   // one whole frame
    $display("pass_through: %0d failures", fail_total() - base);

    base = fail_total();
    foreach (step_order[i]) begin
      pulse_ctrl();
      compare("filter_sel", filter_sel, step_order[i]);
    end
    $display("filter_step: %0d failures", fail_total() - base);

    base = fail_total();
    make_red_frame();
    send_frame();
    wait_clk(sweep_wait);
    compare("centroid", centroid, 24);    // floor((20 + 29) / 2)
    compare("proximity", proximity, 3);   // 100 matches, top bit 6
    compare("filter_sel", filter_sel, filt_red);
    check_display(95 * 800, 24);          // sync lines through the last window row
    $display("red_tracking: %0d failures", fail_total() - base);

    $display("tests 4, checks %0d, failures %0d", checks, fail_total());
    if (fail_total() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < timeout_cyc) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cyc);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== verif/top_ov7670_props.sv ====
`timescale 1ns/1ps

module top_ov7670_props (
  input logic                 clk,
  input logic                 rst_n,
  input logic [3:0]           vga_red,
  input logic [3:0]           vga_green,
  input logic [3:0]           vga_blue,
  input logic                 vga_hsync,
  input logic                 vga_vsync,
  input logic [7:0]           centroid,
  input logic [2:0]           proximity,
  input ov7670_pkg::filter_t  filter_sel,
  input logic                 cap_we,
  input logic                 proc_we
);

  import ov7670_pkg::*;

  localparam int hs_low_cyc = 192;             // 96 pixels at half rate
  localparam int line_cyc   = 1600;            // 800 pixels per line
  localparam int vs_low_cyc = 2 * line_cyc;    // two lines
  localparam int frame_cyc  = 525 * line_cyc;

  int   fail_cnt = 0;   // summed into the testbench result
  logic hs_q;
  logic vs_q;
  logic hs_seen;        // a full line period is measurable after the first fall
  logic vs_seen;
  int   hs_low;
  int   hs_line;
  int   vs_low;
  int   vs_frame;
  logic hs_fall;
  logic hs_rise;
  logic vs_fall;
  logic vs_rise;

  assign hs_fall = hs_q & ~vga_hsync;
  assign hs_rise = ~hs_q & vga_hsync;
  assign vs_fall = vs_q & ~vga_vsync;
  assign vs_rise = ~vs_q & vga_vsync;

  // pulse widths and periods in clk cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hs_q     <= 1'b1;
      vs_q     <= 1'b1;
      hs_seen  <= 1'b0;
      vs_seen  <= 1'b0;
      hs_low   <= 0;
      hs_line  <= 0;
      vs_low   <= 0;
      vs_frame <= 0;
    end else begin
      hs_q     <= vga_hsync;
      vs_q     <= vga_vsync;
      hs_seen  <= hs_seen | hs_fall;
      vs_seen  <= vs_seen | vs_fall;
      hs_low   <= vga_hsync ? 0 : hs_low + 1;
      vs_low   <= vga_vsync ? 0 : vs_low + 1;
      hs_line  <= hs_fall ? 1 : hs_line + 1;   // restarts at each line
      vs_frame <= vs_fall ? 1 : vs_frame + 1;
    end
  end

  reset_state_a: assert property (@(posedge clk) !rst_n |=>
    vga_hsync && vga_vsync && {vga_red, vga_green, vga_blue} == 12'h000 &&
    !cap_we && !proc_we && centroid == 8'd0 && proximity == 3'd0 && filter_sel == filt_none)
  else begin
    $error("outputs are not in their reset state during or right after reset");
    fail_cnt++;
  end

  hs_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    hs_rise |-> hs_low == hs_low_cyc)
  else begin
    $error("hsync low for %0d cycles, expected %0d", hs_low, hs_low_cyc);
    fail_cnt++;
  end

  line_a: assert property (@(posedge clk) disable iff (!rst_n)
    hs_fall && hs_seen |-> hs_line == line_cyc)
  else begin
    $error("line lasted %0d cycles, expected %0d", hs_line, line_cyc);
    fail_cnt++;
  end

  vs_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    vs_rise |-> vs_low == vs_low_cyc)
  else begin
    $error("vsync low for %0d cycles, expected %0d", vs_low, vs_low_cyc);
    fail_cnt++;
  end

  frame_a: assert property (@(posedge clk) disable iff (!rst_n)
    vs_fall && vs_seen |-> vs_frame == frame_cyc)
  else begin
    $error("frame lasted %0d cycles, expected %0d", vs_frame, frame_cyc);
    fail_cnt++;
  end

  // no color during sync pulses
  blank_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!vga_hsync || !vga_vsync) |-> {vga_red, vga_green, vga_blue} == 12'h000)
  else begin
    $error("color output is not black while a sync pulse is active");
    fail_cnt++;
  end

endmodule

bind top_ov7670 top_ov7670_props props0 (
  .clk(clk), .rst_n(rst_n),
  .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
  .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
  .centroid(centroid), .proximity(proximity), .filter_sel(filter_sel),
  .cap_we(cap_we), .proc_we(proc_we)
);
